//--- source/amber_wb_pkg.sv
// ========================================
// shared definitions for the Wishbone master
// covers bus widths, the line layout, the requester
// type and the two views of a bus address
// ========================================

package amber_wb_pkg;

    // bus data and address width
    localparam int DATA_W     = 32;
    // one select bit per byte lane
    localparam int SEL_W      = 4;
    // words in one cache line, which sets the burst length
    localparam int LINE_WORDS = 4;

    // the address word splits into line, word and byte fields
    localparam int WORD_W     = $clog2(LINE_WORDS);
    localparam int OFFSET_W   = $clog2(SEL_W);
    localparam int LINE_W     = DATA_W - WORD_W - OFFSET_W;

    // which requester owns the access now on the bus
    typedef enum logic
    {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } req_src_e;

    // field view of an address, most significant field first
    typedef struct packed
    {
        logic [LINE_W-1:0]   line_idx;
        logic [WORD_W-1:0]   word_idx;
        logic [OFFSET_W-1:0] byte_off;
    } wb_addr_s;

    // the flat view goes on the bus and the field view is stepped in bursts
    typedef union packed
    {
        logic [DATA_W-1:0] flat;
        wb_addr_s          field;
    } wb_addr_u;

endpackage

//--- source/wb_req_if.sv
// ========================================
// request channel from the arbiter to the
// bus cycle controller, with accept and done
// strobes running back
// ========================================
`timescale 1ns/1ps

interface wb_req_if import amber_wb_pkg::*; ();

    // request side, driven by the arbiter
    logic              req_valid;
    req_src_e          req_src;
    logic              req_write;
    logic              req_qword;
    wb_addr_u          req_addr;
    logic [SEL_W-1:0]  req_sel;
    logic [DATA_W-1:0] req_data;

    // accept pulses when the access starts, done on its final acknowledge
    logic              accept;
    logic              done;

    modport arbiter (
        output req_valid, req_src, req_write, req_qword, req_addr, req_sel, req_data,
        input  accept, done
    );

    modport controller (
        input  req_valid, req_src, req_write, req_qword, req_addr, req_sel, req_data,
        output accept, done
    );

endinterface

//--- source/wb_request_arbiter.sv
// ========================================
// request arbiter
// latches instruction and data requests and
// presents one at a time, data first
// ========================================
`timescale 1ns/1ps

module wb_request_arbiter import amber_wb_pkg::*;
(
    input  logic              i_clk,
    input  logic              quick_n_reset,
    input  logic              i_icache_req,
    input  logic              i_icache_qword,
    input  logic [DATA_W-1:0] i_icache_address,
    input  logic              i_dcache_req,
    input  logic              i_dcache_write,
    input  logic [DATA_W-1:0] i_dcache_address,
    input  logic [DATA_W-1:0] i_dcache_write_data,
    input  logic [SEL_W-1:0]  i_dcache_byte_enable,
    wb_req_if.arbiter         req
);

    logic              icache_pend;
    logic              dcache_pend;
    logic              in_service;
    req_src_e          serve_src;
    logic              icache_new;
    logic              dcache_new;
    wb_addr_u          icache_addr_q;
    logic              icache_qword_q;
    wb_addr_u          dcache_addr_q;
    logic              dcache_write_q;
    logic [DATA_W-1:0] dcache_wdata_q;
    logic [SEL_W-1:0]  dcache_be_q;

    // low address bits for a write follow its byte lanes
    function automatic logic [OFFSET_W-1:0] be_offset(input logic [SEL_W-1:0] be);
        case (be)
            4'b0001: be_offset = 2'd0;
            4'b0010: be_offset = 2'd1;
            4'b0100: be_offset = 2'd2;
            4'b1000: be_offset = 2'd3;
            4'b1100: be_offset = 2'd2;
            default: be_offset = 2'd0;
        endcase
    endfunction

    // a request is new on the first edge it shows while its source is not pending
    assign icache_new = i_icache_req && !icache_pend;
    assign dcache_new = i_dcache_req && !dcache_pend;

    // ========================================
    // pending and in-service tracking
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            icache_pend <= 1'b0;
            dcache_pend <= 1'b0;
            in_service  <= 1'b0;
            serve_src   <= SRC_ICACHE;
        end
        else
        begin
            if (icache_new)
                icache_pend <= 1'b1;
            if (dcache_new)
                dcache_pend <= 1'b1;
            // the served source drops its pending bit on the final acknowledge
            if (req.done)
            begin
                in_service <= 1'b0;
                if (serve_src == SRC_DCACHE)
                    dcache_pend <= 1'b0;
                else
                    icache_pend <= 1'b0;
            end
            else if (req.accept)
            begin
                in_service <= 1'b1;
                serve_src  <= req.req_src;
            end
        end
    end

    // request fields are captured once, when the request first arrives
    always_ff @(posedge i_clk)
    begin
        if (icache_new)
        begin
            icache_addr_q.flat <= i_icache_address;
            icache_qword_q     <= i_icache_qword;
        end
        if (dcache_new)
        begin
            dcache_addr_q.flat <= i_dcache_address;
            dcache_write_q     <= i_dcache_write;
            dcache_wdata_q     <= i_dcache_write_data;
            dcache_be_q        <= i_dcache_byte_enable;
        end
    end

    // ========================================
    // fixed priority selection
    // ========================================
    // nothing new is shown while an access is still on the bus
    assign req.req_valid = (icache_pend || dcache_pend) && !in_service;

    always_comb
    begin
        if (dcache_pend)
        begin
            req.req_src                  = SRC_DCACHE;
            req.req_write                = dcache_write_q;
            req.req_qword                = 1'b0;
            req.req_addr.field.line_idx  = dcache_addr_q.field.line_idx;
            req.req_addr.field.word_idx  = dcache_addr_q.field.word_idx;
            // reads fetch the whole word so the offset stays at zero
            req.req_addr.field.byte_off  = dcache_write_q ? be_offset(dcache_be_q) : '0;
            req.req_sel                  = dcache_write_q ? dcache_be_q : '1;
            req.req_data                 = dcache_wdata_q;
        end
        else
        begin
            req.req_src                  = SRC_ICACHE;
            req.req_write                = 1'b0;
            req.req_qword                = icache_qword_q;
            req.req_addr.field.line_idx  = icache_addr_q.field.line_idx;
            req.req_addr.field.word_idx  = icache_addr_q.field.word_idx;
            req.req_addr.field.byte_off  = '0;
            req.req_sel                  = '1;
            req.req_data                 = '0;
        end
    end

    // once shown, a request must wait for the controller to take it
    a_valid_until_accept: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        req.req_valid && !req.accept |=> req.req_valid);

endmodule

//--- source/wb_cycle_ctrl.sv
// ========================================
// Wishbone bus cycle controller
// runs single transfers and wrapping line
// bursts, waits on the slave and raises ready
// ========================================
`timescale 1ns/1ps

module wb_cycle_ctrl import amber_wb_pkg::*;
(
    input  logic              i_clk,
    input  logic              quick_n_reset,
    wb_req_if.controller      req,
    input  logic              i_wb_ack,
    output logic [DATA_W-1:0] o_wb_adr,
    output logic [SEL_W-1:0]  o_wb_sel,
    output logic              o_wb_we,
    output logic [DATA_W-1:0] o_wb_dat,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    output logic              o_icache_ready,
    output logic              o_dcache_ready
);

    typedef enum logic [2:0]
    {
        ST_IDLE     = 3'd0,
        ST_BURST1   = 3'd1,
        ST_BURST2   = 3'd2,
        ST_BURST3   = 3'd3,
        ST_WAIT_ACK = 3'd4
    } wb_state_e;

    wb_state_e state;
    req_src_e  src_q;
    wb_addr_u  adr_q;
    logic      burst_step;
    logic      read_ack;
    logic      write_ack;

    // an access is taken in the idle cycle where the arbiter shows one
    assign req.accept = (state == ST_IDLE) && req.req_valid;
    // the wait_ack state always holds the last word of an access
    assign req.done   = (state == ST_WAIT_ACK) && i_wb_ack;

    // the first three words of a line fill step the word index
    assign burst_step = i_wb_ack &&
                        (state == ST_BURST1 || state == ST_BURST2 || state == ST_BURST3);

    assign o_wb_adr = adr_q.flat;

    // ========================================
    // ready generation
    // ========================================
    // ready follows the acknowledge combinationally, never in idle
    assign read_ack  = o_wb_stb && !o_wb_we && i_wb_ack;
    assign write_ack = o_wb_stb &&  o_wb_we && i_wb_ack;

    assign o_icache_ready = (src_q == SRC_ICACHE) && read_ack;
    assign o_dcache_ready = (src_q == SRC_DCACHE) && (read_ack || write_ack);

    // ========================================
    // bus cycle state machine
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state    <= ST_IDLE;
            src_q    <= SRC_ICACHE;
            o_wb_stb <= 1'b0;
            o_wb_cyc <= 1'b0;
            o_wb_we  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (req.accept)
                    begin
                        o_wb_stb <= 1'b1;
                        o_wb_cyc <= 1'b1;
                        o_wb_we  <= req.req_write;
                        src_q    <= req.req_src;
                        // a quad request walks the line, anything else is one word
                        state    <= req.req_qword ? ST_BURST1 : ST_WAIT_ACK;
                    end
                end
                ST_BURST1:
                    if (i_wb_ack)
                        state <= ST_BURST2;
                ST_BURST2:
                    if (i_wb_ack)
                        state <= ST_BURST3;
                ST_BURST3:
                    if (i_wb_ack)
                        state <= ST_WAIT_ACK;
                ST_WAIT_ACK:
                begin
                    // the bus goes quiet for at least one cycle after the last word
                    if (i_wb_ack)
                    begin
                        state    <= ST_IDLE;
                        o_wb_stb <= 1'b0;
                        o_wb_cyc <= 1'b0;
                        o_wb_we  <= 1'b0;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // address, select and write data are loaded at the start of an access
    always_ff @(posedge i_clk)
    begin
        if (req.accept)
        begin
            adr_q.flat <= req.req_addr.flat;
            o_wb_sel   <= req.req_sel;
            o_wb_dat   <= req.req_data;
        end
        else if (burst_step)
        begin
            // only the word index moves so the burst wraps inside the line
            adr_q.field.word_idx <= adr_q.field.word_idx + WORD_W'(1);
        end
    end

    // leaving idle puts the requested address on the bus
    a_idle_next: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state == ST_IDLE |=> state inside {ST_IDLE, ST_BURST1, ST_WAIT_ACK} &&
            (state == ST_IDLE || o_wb_adr == $past(req.req_addr.flat)));
    // each burst word moves the state and the word index on together
    a_burst1_step: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state == ST_BURST1 && i_wb_ack |=> state == ST_BURST2 &&
            adr_q.field.word_idx == $past(adr_q.field.word_idx) + WORD_W'(1));
    a_burst2_step: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state == ST_BURST2 && i_wb_ack |=> state == ST_BURST3 &&
            adr_q.field.word_idx == $past(adr_q.field.word_idx) + WORD_W'(1));
    a_burst3_step: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state == ST_BURST3 && i_wb_ack |=> state == ST_WAIT_ACK &&
            adr_q.field.word_idx == $past(adr_q.field.word_idx) + WORD_W'(1));
    // under back-pressure the strobe and address stay put
    a_stb_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr));

endmodule

//--- source/wb_master_top.sv
// ========================================
// Wishbone bus master top level
// joins the request arbiter and the
// bus cycle controller
// ========================================
`timescale 1ns/1ps

module wb_master_top import amber_wb_pkg::*;
(
    input  logic              i_clk,
    input  logic              quick_n_reset,

    // instruction cache port
    input  logic              i_icache_req,
    input  logic              i_icache_qword,
    input  logic [DATA_W-1:0] i_icache_address,
    output logic [DATA_W-1:0] o_icache_read_data,
    output logic              o_icache_ready,

    // data port
    input  logic              i_dcache_req,
    input  logic              i_dcache_write,
    input  logic [DATA_W-1:0] i_dcache_address,
    input  logic [DATA_W-1:0] i_dcache_write_data,
    input  logic [SEL_W-1:0]  i_dcache_byte_enable,
    output logic [DATA_W-1:0] o_dcache_read_data,
    output logic              o_dcache_ready,

    // Wishbone bus
    output logic [DATA_W-1:0] o_wb_adr,
    output logic [SEL_W-1:0]  o_wb_sel,
    output logic              o_wb_we,
    output logic [DATA_W-1:0] o_wb_dat,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    input  logic [DATA_W-1:0] i_wb_dat,
    input  logic              i_wb_ack
);

    wb_req_if u_req_if ();

    // read data goes straight from the bus to both requesters
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

    wb_request_arbiter u_arbiter (
        .i_clk                (i_clk),
        .quick_n_reset        (quick_n_reset),
        .i_icache_req         (i_icache_req),
        .i_icache_qword       (i_icache_qword),
        .i_icache_address     (i_icache_address),
        .i_dcache_req         (i_dcache_req),
        .i_dcache_write       (i_dcache_write),
        .i_dcache_address     (i_dcache_address),
        .i_dcache_write_data  (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable),
        .req                  (u_req_if.arbiter)
    );

    wb_cycle_ctrl u_cycle (
        .i_clk          (i_clk),
        .quick_n_reset  (quick_n_reset),
        .req            (u_req_if.controller),
        .i_wb_ack       (i_wb_ack),
        .o_wb_adr       (o_wb_adr),
        .o_wb_sel       (o_wb_sel),
        .o_wb_we        (o_wb_we),
        .o_wb_dat       (o_wb_dat),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_icache_ready (o_icache_ready),
        .o_dcache_ready (o_dcache_ready)
    );

endmodule

//--- dv/tb_wb_master.sv
// ========================================
// testbench for the Wishbone bus master
// replays golden transactions against a slave
// memory with random wait states
// ========================================
`timescale 1ns/1ps

module tb_wb_master import amber_wb_pkg::*; ();

    localparam int MAX_LINES = 64;
    localparam int MEM_WORDS = 256;
    // golden file columns
    localparam int COL_OP    = 0;
    localparam int COL_SRC   = 1;
    localparam int COL_ADDR  = 2;
    localparam int COL_BE    = 3;
    localparam int COL_WDATA = 4;
    localparam int COL_QWORD = 5;
    localparam int COL_EXP   = 6;

    logic              i_clk;
    logic              quick_n_reset;
    logic              i_icache_req;
    logic              i_icache_qword;
    logic [DATA_W-1:0] i_icache_address;
    logic [DATA_W-1:0] o_icache_read_data;
    logic              o_icache_ready;
    logic              i_dcache_req;
    logic              i_dcache_write;
    logic [DATA_W-1:0] i_dcache_address;
    logic [DATA_W-1:0] i_dcache_write_data;
    logic [SEL_W-1:0]  i_dcache_byte_enable;
    logic [DATA_W-1:0] o_dcache_read_data;
    logic              o_dcache_ready;
    logic [DATA_W-1:0] o_wb_adr;
    logic [SEL_W-1:0]  o_wb_sel;
    logic              o_wb_we;
    logic [DATA_W-1:0] o_wb_dat;
    logic              o_wb_cyc;
    logic              o_wb_stb;
    logic [DATA_W-1:0] wb_rdata = '0;
    logic              wb_ack = 1'b0;

    logic [DATA_W-1:0] mem [0:MEM_WORDS-1];
    logic [DATA_W-1:0] golden [MAX_LINES][10];
    logic [DATA_W-1:0] col [10];
    integer            seed = 32'h13d6;
    int                delay_now;
    int                wait_cnt = 0;
    logic              armed = 1'b0;
    logic              prev_stb = 1'b0;
    logic              prev_ack = 1'b0;
    logic [DATA_W-1:0] prev_adr = '0;
    int                err_cnt = 0;
    int                check_cnt = 0;
    int                test_cnt = 0;
    int                line_cnt = 0;
    int                cycle_cnt = 0;
    int                cycle_limit = 100;

    wb_master_top u_dut (
        .i_clk                (i_clk),
        .quick_n_reset        (quick_n_reset),
        .i_icache_req         (i_icache_req),
        .i_icache_qword       (i_icache_qword),
        .i_icache_address     (i_icache_address),
        .o_icache_read_data   (o_icache_read_data),
        .o_icache_ready       (o_icache_ready),
        .i_dcache_req         (i_dcache_req),
        .i_dcache_write       (i_dcache_write),
        .i_dcache_address     (i_dcache_address),
        .i_dcache_write_data  (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable),
        .o_dcache_read_data   (o_dcache_read_data),
        .o_dcache_ready       (o_dcache_ready),
        .o_wb_adr             (o_wb_adr),
        .o_wb_sel             (o_wb_sel),
        .o_wb_we              (o_wb_we),
        .o_wb_dat             (o_wb_dat),
        .o_wb_cyc             (o_wb_cyc),
        .o_wb_stb             (o_wb_stb),
        .i_wb_dat             (wb_rdata),
        .i_wb_ack             (wb_ack)
    );

    always #5 i_clk = ~i_clk;

    // byte offset a write must carry on the bus, single lanes give their own byte
    function automatic logic [OFFSET_W-1:0] lane_offset(input logic [SEL_W-1:0] be);
        if (be == 4'b0010)
            return 2'd1;
        else if (be == 4'b0100 || be == 4'b1100)
            return 2'd2;
        else if (be == 4'b1000)
            return 2'd3;
        return 2'd0;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [SEL_W-1:0]  sel);
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < SEL_W; b++)
            if (sel[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        return merged;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("FAIL %s got=%h expected=%h", name, got, exp);
        end
    endtask

    // ========================================
    // slave memory with 0 to 2 wait cycles
    // ========================================
    // ack and read data are registered, so each word takes at least one cycle
    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            wb_ack <= 1'b0;
            armed  <= 1'b0;
            // every word holds its own byte address under a fixed upper pattern
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= 32'h5a5a_0000 + 32'(i) * 4;
        end
        else
        begin
            wb_ack <= 1'b0;
            if (o_wb_stb && !wb_ack)
            begin
                // a new word draws its delay, a waiting one keeps counting down
                if (armed)
                    delay_now = wait_cnt;
                else
                    delay_now = {$random(seed)} % 3;
                if (delay_now == 0)
                begin
                    wb_ack <= 1'b1;
                    armed  <= 1'b0;
                    if (o_wb_we)
                        mem[o_wb_adr[9:2]] <= merge_bytes(mem[o_wb_adr[9:2]], o_wb_dat, o_wb_sel);
                    else
                        wb_rdata <= mem[o_wb_adr[9:2]];
                end
                else
                begin
                    armed    <= 1'b1;
                    wait_cnt <= delay_now - 1;
                end
            end
        end
    end

    // bus rules that hold for every access, whatever the golden line
    always @(posedge i_clk)
    begin
        if (quick_n_reset)
        begin
            if ((o_icache_ready || o_dcache_ready) && !wb_ack)
            begin
                err_cnt++;
                $display("a ready output was raised without an acknowledge from the slave");
            end
            if (prev_stb && !prev_ack)
            begin
                check_value("o_wb_stb", 32'(o_wb_stb), 32'd1);
                check_value("o_wb_adr", o_wb_adr, prev_adr);
            end
        end
        prev_stb <= o_wb_stb;
        prev_ack <= wb_ack;
        prev_adr <= o_wb_adr;
    end

    always @(posedge i_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout after %0d cycles, an access never completed", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    // ========================================
    // one golden line, one or two accesses
    // ========================================
    task automatic run_line(input int n);
        logic [DATA_W-1:0] op;
        logic              use_i;
        logic              use_d;
        logic              is_write;
        logic              qword;
        logic [DATA_W-1:0] i_addr;
        logic [DATA_W-1:0] d_adr_exp;
        logic [SEL_W-1:0]  be;
        int                i_words;
        int                i_got;
        int                d_got;
        int                word;
        int                errs_before;

        op          = golden[n][COL_OP];
        is_write    = (op == 1);
        use_d       = is_write || op == 2 || (op == 0 && golden[n][COL_SRC] == 1);
        use_i       = op == 2 || (op == 0 && golden[n][COL_SRC] == 0);
        qword       = (op == 0) && use_i && golden[n][COL_QWORD][0];
        i_addr      = (op == 2) ? golden[n][COL_WDATA] : golden[n][COL_ADDR];
        be          = is_write ? golden[n][COL_BE][SEL_W-1:0] : '1;
        i_words     = use_i ? (qword ? LINE_WORDS : 1) : 0;
        i_got       = 0;
        d_got       = use_d ? 0 : 1;
        errs_before = err_cnt;
        // writes carry the lane offset, reads are word aligned
        d_adr_exp   = {golden[n][COL_ADDR][DATA_W-1:2], is_write ? lane_offset(be) : 2'b00};

        @(posedge i_clk);
        i_icache_req         <= use_i;
        i_icache_qword       <= qword;
        i_icache_address     <= i_addr;
        i_dcache_req         <= use_d;
        i_dcache_write       <= is_write;
        i_dcache_address     <= golden[n][COL_ADDR];
        i_dcache_write_data  <= golden[n][COL_WDATA];
        i_dcache_byte_enable <= golden[n][COL_BE][SEL_W-1:0];

        while (i_got < i_words || d_got < 1)
        begin
            @(posedge i_clk);
            if (o_dcache_ready)
            begin
                check_value("o_wb_cyc", 32'(o_wb_cyc), 32'd1);
                check_value("o_wb_we", 32'(o_wb_we), 32'(is_write));
                check_value("o_wb_adr", o_wb_adr, d_adr_exp);
                check_value("o_wb_sel", 32'(o_wb_sel), 32'(be));
                if (is_write)
                    check_value("o_wb_dat", o_wb_dat, golden[n][COL_WDATA]);
                else
                    check_value("o_dcache_read_data", o_dcache_read_data, golden[n][COL_EXP]);
                d_got = 1;
                i_dcache_req <= 1'b0;
            end
            if (o_icache_ready)
            begin
                if (use_d && d_got == 0)
                begin
                    err_cnt++;
                    $display("instruction ready came before the data access completed");
                end
                // a line fill wraps inside the line from the requested word
                word = (int'(i_addr[3:2]) + i_got) % LINE_WORDS;
                check_value("o_wb_cyc", 32'(o_wb_cyc), 32'd1);
                check_value("o_wb_adr", o_wb_adr, {i_addr[DATA_W-1:4], 2'(word), 2'b00});
                check_value("o_wb_sel", 32'(o_wb_sel), 32'hf);
                check_value("o_icache_read_data", o_icache_read_data,
                            golden[n][COL_EXP + ((op == 2) ? 1 : i_got)]);
                i_got++;
                if (i_got == i_words)
                    i_icache_req <= 1'b0;
            end
            else if (qword && i_got > 0)
                check_value("o_wb_stb", 32'(o_wb_stb), 32'd1);
        end
        test_cnt++;
        $display("test %0d op %0d addr %h: %s", n + 1, op, golden[n][COL_ADDR],
                 (err_cnt == errs_before) ? "ok" : "mismatch");
    endtask

    initial
    begin
        int    fd;
        int    code;
        int    fields;
        string text;

        i_clk                = 1'b0;
        quick_n_reset        = 1'b0;
        i_icache_req         = 1'b0;
        i_icache_qword       = 1'b0;
        i_icache_address     = '0;
        i_dcache_req         = 1'b0;
        i_dcache_write       = 1'b0;
        i_dcache_address     = '0;
        i_dcache_write_data  = '0;
        i_dcache_byte_enable = '0;

        // comment lines hold no hex fields and are skipped by the field count
        fd = $fopen("dv/wb_golden.txt", "r");
        if (fd == 0)
        begin
            err_cnt++;
            $display("could not open the golden file dv/wb_golden.txt");
        end
        else
        begin
            while (!$feof(fd) && line_cnt < MAX_LINES)
            begin
                text = "";
                code = $fgets(text, fd);
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                                 col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
                if (code > 0 && fields == 10)
                begin
                    golden[line_cnt] = col;
                    line_cnt++;
                end
            end
            $fclose(fd);
            if (line_cnt == 0)
            begin
                err_cnt++;
                $display("the golden file holds no transactions");
            end
        end
        cycle_limit = line_cnt * LINE_WORDS * 5 + 100;

        repeat (4) @(posedge i_clk);
        quick_n_reset <= 1'b1;
        @(posedge i_clk);
        check_value("o_wb_stb", 32'(o_wb_stb), 32'd0);
        check_value("o_wb_cyc", 32'(o_wb_cyc), 32'd0);
        check_value("o_wb_we", 32'(o_wb_we), 32'd0);
        check_value("o_icache_ready", 32'(o_icache_ready), 32'd0);
        check_value("o_dcache_ready", 32'(o_dcache_ready), 32'd0);
        test_cnt++;
        $display("test 0 reset: %s", (err_cnt == 0) ? "ok" : "mismatch");

        for (int n = 0; n < line_cnt; n++)
            run_line(n);

        repeat (2) @(posedge i_clk);
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- vlog.f
source/amber_wb_pkg.sv
source/wb_req_if.sv
source/wb_request_arbiter.sv
source/wb_cycle_ctrl.sv
source/wb_master_top.sv
dv/tb_wb_master.sv

//--- Makefile
# Verilator build and run for the Wishbone bus master testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_master
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/wb_golden.txt
// op: 0 read, 1 write, 2 data read and instruction read together (icache address in wdata)
// op src addr be wdata qword exp0 exp1 exp2 exp3 (hex, src 0 icache, src 1 dcache)
0 0 00000044 f 00000000 0 5a5a0044 00000000 00000000 00000000
0 0 00000103 f 00000000 0 5a5a0100 00000000 00000000 00000000
0 0 00000048 f 00000000 1 5a5a0048 5a5a004c 5a5a0040 5a5a0044
0 0 00000200 f 00000000 1 5a5a0200 5a5a0204 5a5a0208 5a5a020c
0 0 0000011c f 00000000 1 5a5a011c 5a5a0110 5a5a0114 5a5a0118
0 1 00000080 f 00000000 0 5a5a0080 00000000 00000000 00000000
1 1 00000080 f 11223344 0 00000000 00000000 00000000 00000000
0 1 00000080 f 00000000 0 11223344 00000000 00000000 00000000
1 1 00000084 1 000000ee 0 00000000 00000000 00000000 00000000
0 1 00000084 f 00000000 0 5a5a00ee 00000000 00000000 00000000
1 1 00000088 2 0000bb00 0 00000000 00000000 00000000 00000000
0 1 00000088 f 00000000 0 5a5abb88 00000000 00000000 00000000
1 1 0000008c 4 00cc0000 0 00000000 00000000 00000000 00000000
0 1 0000008c f 00000000 0 5acc008c 00000000 00000000 00000000
1 1 00000090 8 dd000000 0 00000000 00000000 00000000 00000000
0 1 00000090 f 00000000 0 dd5a0090 00000000 00000000 00000000
1 1 00000094 c 77660000 0 00000000 00000000 00000000 00000000
0 1 00000094 f 00000000 0 77660094 00000000 00000000 00000000
1 1 00000098 3 0000abcd 0 00000000 00000000 00000000 00000000
0 1 00000098 f 00000000 0 5a5aabcd 00000000 00000000 00000000
2 1 00000080 f 000000c0 0 11223344 5a5a00c0 00000000 00000000
2 1 00000094 f 000000d4 0 77660094 5a5a00d4 00000000 00000000
0 0 00000088 f 00000000 1 5a5abb88 5acc008c 11223344 5a5a00ee
